// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run; the exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -f tb.f \
    --top-module tb_remove_rows --Mdir obj_dir -o sim_remove_rows \
    && ./obj_dir/sim_remove_rows \
    || { echo "simulation did not complete successfully"; exit 1; }

// ==== source/crop_lane.sv ====
// crop_lane: per-stream frame FSM that loads sizes, drops leading rows and forwards the rest
`timescale 1ns/10ps

module crop_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  grant,
    input  logic                  pel_empty,
    input  remove_rows_pkg::pel_t  pel_data,
    input  logic                  ext_size_empty,
    input  remove_rows_pkg::size_t ext_size_data,
    input  logic                  real_size_empty,
    input  remove_rows_pkg::size_t real_size_data,
    input  logic                  out_full,
    output logic                  req,
    output logic                  pel_rd,
    output logic                  ext_size_rd,
    output logic                  real_size_rd,
    output logic                  pel_valid,
    output remove_rows_pkg::pel_t  pel_out
);

    import remove_rows_pkg::*;

    lane_state_t state;

    // position inside the current frame
    size_t row_cnt;
    size_t col_cnt;

    // frame size latched from the size FIFOs
    size_t row_max;
    size_t col_max;

    logic act;
    logic last_col;
    logic last_drop_row;
    logic last_row;

    // ready to act this cycle, judged from the lane's own FIFOs
    always_comb
    begin
        case (state)
            LANE_IDLE: req = !ext_size_empty && !real_size_empty;
            LANE_DROP: req = !pel_empty;
            LANE_WORK: req = !pel_empty && !out_full;
            default:   req = 1'b0;
        endcase
    end

    assign act = grant && req;

    assign last_col      = (col_cnt == size_t'(col_max - 1'b1));
    assign last_drop_row = (row_cnt == size_t'(DROP_ROWS - 1));
    assign last_row      = (row_cnt == size_t'(row_max - 1'b1));

    // strobes for the granted action
    assign ext_size_rd  = act && (state == LANE_IDLE);
    assign real_size_rd = act && (state == LANE_IDLE);
    assign pel_rd       = act && (state == LANE_DROP || state == LANE_WORK);
    assign pel_valid    = act && (state == LANE_WORK);

    // the pixel passes straight on, same cycle as its read
    assign pel_out = pel_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= LANE_IDLE;
            row_cnt <= '0;
            col_cnt <= '0;
        end
        else if (act)
        begin
            case (state)
                LANE_IDLE:
                begin
                    row_cnt <= '0;
                    col_cnt <= '0;
                    state   <= LANE_DROP;
                end
                LANE_DROP:
                begin
                    if (last_col)
                    begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                        // row count keeps running into the work phase
                        if (last_drop_row)
                            state <= LANE_WORK;
                    end
                    else
                        col_cnt <= col_cnt + 1'b1;
                end
                LANE_WORK:
                begin
                    if (last_col)
                    begin
                        col_cnt <= '0;
                        if (last_row)
                        begin
                            row_cnt <= '0;
                            state   <= LANE_IDLE;
                        end
                        else
                            row_cnt <= row_cnt + 1'b1;
                    end
                    else
                        col_cnt <= col_cnt + 1'b1;
                end
                default:
                    state <= LANE_IDLE;
            endcase
        end
    end

    // frame size capture
    always_ff @(posedge clk)
    begin
        if (ext_size_rd)
        begin
            row_max <= ext_size_data;
            col_max <= real_size_data;
        end
    end

    a_no_empty_read: assert property (
        @(posedge clk) disable iff (rst)
        !(pel_rd && pel_empty) && !(ext_size_rd && ext_size_empty)
            && !(real_size_rd && real_size_empty)
    )
    else
        $error("crop_lane: read strobe on an empty FIFO");

    // every frame must leave at least one row after the drop phase
    a_rows_exceed_drop: assert property (
        @(posedge clk) disable iff (rst)
        ext_size_rd |-> (ext_size_data > size_t'(DROP_ROWS))
    )
    else
        $error("crop_lane: row count %0d not above %0d", ext_size_data, DROP_ROWS);

    a_row_len_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        real_size_rd |-> (real_size_data != '0)
    )
    else
        $error("crop_lane: zero row length loaded");

endmodule

// ==== source/output_merge.sv ====
// output_merge: one-hot mux of the active lane's pixel onto the shared tagged output
`timescale 1ns/10ps

module output_merge #(
    parameter int NUM_STREAMS = 2,
    localparam int TAG_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1
)(
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [NUM_STREAMS-1:0]                   pel_valid,
    input  remove_rows_pkg::pel_t                     pel_out [NUM_STREAMS],
    output logic                                     out_wr,
    output logic [TAG_W+remove_rows_pkg::PEL_WIDTH-1:0] out_data
);

    import remove_rows_pkg::*;

    pel_t             pel_mux;
    logic [TAG_W-1:0] tag;

    // only one lane is valid, so OR-ing gives the selected pixel and index
    always_comb
    begin
        pel_mux = '0;
        tag     = '0;
        for (int i = 0; i < NUM_STREAMS; i++)
        begin
            if (pel_valid[i])
            begin
                pel_mux = pel_mux | pel_out[i];
                tag     = tag | TAG_W'(i);
            end
        end
    end

    assign out_wr   = |pel_valid;
    assign out_data = {tag, pel_mux};

    // lanes act only under the arbiter's grant, so two writers never meet here
    a_single_writer: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(pel_valid)
    )
    else
        $error("output_merge: several lanes valid %b", pel_valid);

endmodule

// ==== source/remove_rows_pkg.sv ====
// remove_rows_pkg: shared widths, crop depth and types of the multi-stream row cropper
package remove_rows_pkg;

    // pixel word width
    localparam int PEL_WIDTH = 8;

    // row count and row length width
    localparam int SIZE_WIDTH = 7;

    // leading rows discarded from every frame
    localparam int DROP_ROWS = 7;

    // one pixel as read from a stream FIFO
    typedef logic [PEL_WIDTH-1:0] pel_t;

    // row count or row length of a frame
    typedef logic [SIZE_WIDTH-1:0] size_t;

    // per-lane frame phase
    typedef enum logic [1:0]
    {
        // waiting for both frame sizes
        LANE_IDLE = 2'd0,
        // discarding the leading rows
        LANE_DROP = 2'd1,
        // forwarding the remaining rows
        LANE_WORK = 2'd2
    } lane_state_t;

endpackage

// ==== source/remove_rows_top.sv ====
// remove_rows_top: multi-stream row cropper with arbiter, crop lanes and tagged output merge
`timescale 1ns/10ps

module remove_rows_top #(
    parameter int NUM_STREAMS = 2,
    localparam int TAG_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1
)(
    input  logic                                     clk,
    input  logic                                     rst,

    // pixel FIFOs
    input  logic [NUM_STREAMS-1:0]                   pel_empty,
    input  remove_rows_pkg::pel_t                     pel_data [NUM_STREAMS],
    output logic [NUM_STREAMS-1:0]                   pel_rd,

    // row count FIFOs
    input  logic [NUM_STREAMS-1:0]                   ext_size_empty,
    input  remove_rows_pkg::size_t                    ext_size_data [NUM_STREAMS],
    output logic [NUM_STREAMS-1:0]                   ext_size_rd,

    // row length FIFOs
    input  logic [NUM_STREAMS-1:0]                   real_size_empty,
    input  remove_rows_pkg::size_t                    real_size_data [NUM_STREAMS],
    output logic [NUM_STREAMS-1:0]                   real_size_rd,

    // shared output FIFO, full flag per stream
    input  logic [NUM_STREAMS-1:0]                   out_full,
    output logic                                     out_wr,
    output logic [TAG_W+remove_rows_pkg::PEL_WIDTH-1:0] out_data
);

    import remove_rows_pkg::*;

    logic [NUM_STREAMS-1:0] lane_req;
    logic [NUM_STREAMS-1:0] lane_grant;
    logic [NUM_STREAMS-1:0] lane_valid;
    pel_t                   lane_pel [NUM_STREAMS];

    stream_arbiter #(
        .NUM_STREAMS (NUM_STREAMS)
    ) i_arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (lane_req),
        .grant (lane_grant)
    );

    // one crop lane per stream
    for (genvar i = 0; i < NUM_STREAMS; i++)
    begin : g_lane
        crop_lane i_lane (
            .clk             (clk),
            .rst             (rst),
            .grant           (lane_grant[i]),
            .pel_empty       (pel_empty[i]),
            .pel_data        (pel_data[i]),
            .ext_size_empty  (ext_size_empty[i]),
            .ext_size_data   (ext_size_data[i]),
            .real_size_empty (real_size_empty[i]),
            .real_size_data  (real_size_data[i]),
            .out_full        (out_full[i]),
            .req             (lane_req[i]),
            .pel_rd          (pel_rd[i]),
            .ext_size_rd     (ext_size_rd[i]),
            .real_size_rd    (real_size_rd[i]),
            .pel_valid       (lane_valid[i]),
            .pel_out         (lane_pel[i])
        );
    end

    output_merge #(
        .NUM_STREAMS (NUM_STREAMS)
    ) i_merge (
        .clk       (clk),
        .rst       (rst),
        .pel_valid (lane_valid),
        .pel_out   (lane_pel),
        .out_wr    (out_wr),
        .out_data  (out_data)
    );

endmodule

// ==== source/stream_arbiter.sv ====
// stream_arbiter: fixed-priority one-hot grant of the lowest requesting lane
`timescale 1ns/10ps

module stream_arbiter #(
    parameter int NUM_STREAMS = 2
)(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_STREAMS-1:0] req,
    output logic [NUM_STREAMS-1:0] grant
);

    logic [NUM_STREAMS-1:0] req_neg;

    // two's complement of req, so that the AND keeps only the lowest set bit
    assign req_neg = ~req + NUM_STREAMS'(1);

    always_comb
    begin
        grant = req & req_neg;
    end

    // grant is one-hot or empty and never reaches a lane that is not asking
    a_grant_legal: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant & ~req) == '0)
    )
    else
        $error("stream_arbiter: illegal grant %b for req %b", grant, req);

endmodule

// ==== tb.f ====
+incdir+include
source/remove_rows_pkg.sv
source/stream_arbiter.sv
source/crop_lane.sv
source/output_merge.sv
source/remove_rows_top.sv
verif/tb_remove_rows.sv

// ==== include/tb_frame_table.svh ====
// tb_frame_table: frames per stream with sizes and output stall patterns for the cropper testbench
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// behavior of a stream's out_full during one batch
typedef enum int
{
    STALL_NONE,
    STALL_HOLD,
    STALL_RANDOM
} stall_t;

// columns: batch, stream, row count, row length, stall mode
typedef struct packed
{
    int     batch;
    int     stream;
    int     rows;
    int     len;
    stall_t stall;
} frame_row_t;

localparam int NUM_BATCHES      = 4;
localparam int NUM_FRAMES       = 11;
localparam int HOLD_CYCLES      = 150;
localparam int INTERLEAVE_BATCH = 1;

localparam frame_row_t FRAME_TABLE [NUM_FRAMES] = '{
    // single frame on stream 0
    '{0, 0, 10, 6, STALL_NONE},
    // stream 0 stalls at random, so stream 1 gets slots
    '{1, 0, 20, 6, STALL_RANDOM},
    '{1, 1, 11, 4, STALL_NONE},
    '{1, 1, 8, 7, STALL_NONE},
    // stream 1 held full for a while
    '{2, 0, 9, 6, STALL_NONE},
    '{2, 1, 10, 5, STALL_HOLD},
    // back-to-back frames of different sizes
    '{3, 0, 8, 3, STALL_NONE},
    '{3, 0, 12, 9, STALL_NONE},
    '{3, 0, 9, 1, STALL_NONE},
    '{3, 1, 13, 2, STALL_RANDOM},
    '{3, 1, 8, 10, STALL_RANDOM}
};

`endif

// ==== verif/tb_remove_rows.sv ====
// tb_remove_rows: testbench of the row cropper with FIFO models and a per-stream reference
`timescale 1ns/10ps

module tb_remove_rows;

    import remove_rows_pkg::*;

    localparam int NUM_STREAMS   = 2;
    localparam int TAG_W         = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;
    localparam int DRAIN_TIMEOUT = 4000;

    typedef logic [TAG_W-1:0] tag_t;

    `include "tb_frame_table.svh"

    logic                       clk;
    logic                       rst;
    logic [NUM_STREAMS-1:0]     pel_empty;
    pel_t                       pel_data [NUM_STREAMS];
    logic [NUM_STREAMS-1:0]     pel_rd;
    logic [NUM_STREAMS-1:0]     ext_size_empty;
    size_t                      ext_size_data [NUM_STREAMS];
    logic [NUM_STREAMS-1:0]     ext_size_rd;
    logic [NUM_STREAMS-1:0]     real_size_empty;
    size_t                      real_size_data [NUM_STREAMS];
    logic [NUM_STREAMS-1:0]     real_size_rd;
    logic [NUM_STREAMS-1:0]     out_full;
    logic                       out_wr;
    logic [TAG_W+PEL_WIDTH-1:0] out_data;

    // FIFO contents and reference output per stream
    pel_t  pel_q  [NUM_STREAMS][$];
    size_t ext_q  [NUM_STREAMS][$];
    size_t real_q [NUM_STREAMS][$];
    pel_t  exp_q  [NUM_STREAMS][$];

    // strobes seen at the last sample point
    logic [NUM_STREAMS-1:0] pel_taken;
    logic [NUM_STREAMS-1:0] size_taken;

    stall_t stall_mode [NUM_STREAMS];
    int     hold_left  [NUM_STREAMS];
    int     out_cnt    [NUM_STREAMS];
    int     exp_cnt    [NUM_STREAMS];
    int     load_cnt   [NUM_STREAMS];
    int     frame_cnt  [NUM_STREAMS];
    int     other_during_hold;
    int     tag_switches;
    int     last_tag;
    int     strobe_cnt;
    bit     hold_in_batch;
    int     seed;

    remove_rows_top #(
        .NUM_STREAMS (NUM_STREAMS)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .pel_empty       (pel_empty),
        .pel_data        (pel_data),
        .pel_rd          (pel_rd),
        .ext_size_empty  (ext_size_empty),
        .ext_size_data   (ext_size_data),
        .ext_size_rd     (ext_size_rd),
        .real_size_empty (real_size_empty),
        .real_size_data  (real_size_data),
        .real_size_rd    (real_size_rd),
        .out_full        (out_full),
        .out_wr          (out_wr),
        .out_data        (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped at the first failure");
    endtask

    task automatic check_pel(input pel_t expected, input pel_t actual);
        if (actual !== expected)
            abort_run($sformatf("** Error at %0d ns: pixel 0x%02h, expected 0x%02h",
                $time, actual, expected));
    endtask

    task automatic check_tag(input tag_t expected, input tag_t actual);
        if (actual !== expected)
            abort_run($sformatf("** Error at %0d ns: tag %0d, expected %0d",
                $time, actual, expected));
    endtask

    task automatic check_count(input int expected, input int actual, input string what);
        if (actual != expected)
            abort_run($sformatf("** Error at %0d ns: %s is %0d, expected %0d",
                $time, what, actual, expected));
    endtask

    // stream in the top bit, linear position inside the frame below it
    function automatic pel_t pel_pattern(input int stream, input int row, input int len,
                                         input int col);
        logic [PEL_WIDTH-2:0] index;
        index = (PEL_WIDTH-1)'(row * len + col);
        return {stream[0], index};
    endfunction

    task automatic push_frame(input int stream, input int rows, input int len);
        ext_q[stream].push_back(size_t'(rows));
        real_q[stream].push_back(size_t'(len));
        for (int r = 0; r < rows; r++)
        begin
            for (int c = 0; c < len; c++)
            begin
                pel_q[stream].push_back(pel_pattern(stream, r, len, c));
                // only rows past the crop depth reach the output
                if (r >= DROP_ROWS)
                    exp_q[stream].push_back(pel_pattern(stream, r, len, c));
            end
        end
        exp_cnt[stream] += (rows - DROP_ROWS) * len;
        frame_cnt[stream]++;
    endtask

    task automatic drive_fifo_flags();
        for (int s = 0; s < NUM_STREAMS; s++)
        begin
            pel_empty[s]       = (pel_q[s].size() == 0);
            ext_size_empty[s]  = (ext_q[s].size() == 0);
            real_size_empty[s] = (real_q[s].size() == 0);
            pel_data[s]        = pel_empty[s] ? '0 : pel_q[s][0];
            ext_size_data[s]   = ext_size_empty[s] ? '0 : ext_q[s][0];
            real_size_data[s]  = real_size_empty[s] ? '0 : real_q[s][0];
        end
    endtask

    task automatic sample_outputs();
        tag_t tag;
        pel_t expected;
        if ((|pel_rd) || (|ext_size_rd) || (|real_size_rd) || out_wr)
            strobe_cnt++;
        for (int s = 0; s < NUM_STREAMS; s++)
        begin
            if ((pel_rd[s] && pel_empty[s]) || (ext_size_rd[s] && ext_size_empty[s]))
                abort_run($sformatf("stream %0d read an empty FIFO", s));
            if (ext_size_rd[s] !== real_size_rd[s])
                abort_run($sformatf("stream %0d read only one of its size FIFOs", s));
            pel_taken[s]  = pel_rd[s];
            size_taken[s] = ext_size_rd[s];
            if (size_taken[s])
                load_cnt[s]++;
        end
        if (out_wr)
        begin
            tag = out_data[PEL_WIDTH +: TAG_W];
            // every stimulus pixel carries its source stream in the top bit
            check_tag(tag_t'(out_data[PEL_WIDTH-1]), tag);
            if (out_full[tag])
                abort_run($sformatf("output written for stream %0d while it was full", tag));
            if (exp_q[tag].size() == 0)
                abort_run($sformatf("stream %0d wrote more pixels than expected", tag));
            expected = exp_q[tag].pop_front();
            check_pel(expected, out_data[PEL_WIDTH-1:0]);
            out_cnt[tag]++;
            if (last_tag >= 0 && last_tag != int'(tag))
                tag_switches++;
            last_tag = int'(tag);
            for (int s = 0; s < NUM_STREAMS; s++)
                if (stall_mode[s] == STALL_HOLD && out_full[s] && int'(tag) != s)
                    other_during_hold++;
        end
    endtask

    // sample on the falling edge, drive 2 ns after the rising edge
    task automatic step_cycle();
        int rnd;
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #2;
        for (int s = 0; s < NUM_STREAMS; s++)
        begin
            if (pel_taken[s])
                void'(pel_q[s].pop_front());
            if (size_taken[s])
            begin
                void'(ext_q[s].pop_front());
                void'(real_q[s].pop_front());
            end
            rnd = $random(seed);
            case (stall_mode[s])
                STALL_HOLD:   out_full[s] = (hold_left[s] > 0);
                STALL_RANDOM: out_full[s] = rnd[0];
                default:      out_full[s] = 1'b0;
            endcase
            if (hold_left[s] > 0)
                hold_left[s]--;
        end
        drive_fifo_flags();
    endtask

    function automatic bit batch_busy();
        for (int s = 0; s < NUM_STREAMS; s++)
            if (pel_q[s].size() != 0 || ext_q[s].size() != 0 || exp_q[s].size() != 0)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic run_batch(input int batch);
        int cycles;
        int s;
        other_during_hold = 0;
        tag_switches      = 0;
        last_tag          = -1;
        hold_in_batch     = 1'b0;
        for (int i = 0; i < NUM_STREAMS; i++)
            stall_mode[i] = STALL_NONE;
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            if (FRAME_TABLE[f].batch == batch)
            begin
                s = FRAME_TABLE[f].stream;
                push_frame(s, FRAME_TABLE[f].rows, FRAME_TABLE[f].len);
                stall_mode[s] = FRAME_TABLE[f].stall;
                hold_left[s]  = (FRAME_TABLE[f].stall == STALL_HOLD) ? HOLD_CYCLES : 0;
                if (FRAME_TABLE[f].stall == STALL_HOLD)
                    hold_in_batch = 1'b1;
            end
        end
        drive_fifo_flags();
        cycles = 0;
        while (batch_busy())
        begin
            if (cycles >= DRAIN_TIMEOUT)
                abort_run($sformatf("timeout: batch %0d not drained after %0d cycles",
                    batch, cycles));
            step_cycle();
            cycles++;
        end
        if (hold_in_batch && other_during_hold == 0)
            abort_run($sformatf("batch %0d: no other stream ran during the output hold", batch));
        if (batch == INTERLEAVE_BATCH && tag_switches < 2)
            abort_run($sformatf("batch %0d: stream outputs did not interleave", batch));
    endtask

    initial
    begin
        seed            = 32'h34ef09c1;
        rst             = 1'b1;
        pel_empty       = '1;
        ext_size_empty  = '1;
        real_size_empty = '1;
        out_full        = '0;
        pel_taken       = '0;
        size_taken      = '0;
        strobe_cnt      = 0;
        for (int s = 0; s < NUM_STREAMS; s++)
        begin
            pel_data[s]       = '0;
            ext_size_data[s]  = '0;
            real_size_data[s] = '0;
            stall_mode[s]     = STALL_NONE;
            hold_left[s]      = 0;
            out_cnt[s]        = 0;
            exp_cnt[s]        = 0;
            load_cnt[s]       = 0;
            frame_cnt[s]      = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // quiet lanes with every FIFO empty
        repeat (10) step_cycle();
        check_count(0, strobe_cnt, "active strobe cycles with empty FIFOs");

        for (int b = 0; b < NUM_BATCHES; b++)
            run_batch(b);

        for (int s = 0; s < NUM_STREAMS; s++)
        begin
            check_count(exp_cnt[s], out_cnt[s], $sformatf("stream %0d output count", s));
            check_count(frame_cnt[s], load_cnt[s], $sformatf("stream %0d size loads", s));
            check_count(0, pel_q[s].size(), $sformatf("stream %0d pixels left", s));
            check_count(0, ext_q[s].size(), $sformatf("stream %0d row counts left", s));
            check_count(0, real_q[s].size(), $sformatf("stream %0d row lengths left", s));
            check_count(0, exp_q[s].size(), $sformatf("stream %0d expected left", s));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
